//--- common/cnn_pkg.sv
package cnn_pkg;

    // =========================================================================
    // frame geometry
    // =========================================================================
    localparam int IMG_W    = 8;
    localparam int IMG_H    = 8;
    localparam int KSIZE    = 3;
    localparam int CONV_W   = IMG_W - KSIZE + 1;
    localparam int CONV_H   = IMG_H - KSIZE + 1;
    localparam int POOL_W   = CONV_W / 2;
    localparam int POOL_H   = CONV_H / 2;
    localparam int NUM_CH   = 2;
    localparam int COORD_BW = 4;

    // =========================================================================
    // data widths
    // =========================================================================
    localparam int PIX_BW  = 8;
    localparam int PIX_MAX = (1 << PIX_BW) - 1;
    localparam int W_BW    = 4;
    localparam int ACC_BW  = 16;
    localparam int SHIFT   = 2;
    // nine pooled values of 8 bits each
    localparam int SUM_BW  = 12;

    typedef logic [PIX_BW-1:0]          pixel_t;
    typedef logic [PIX_BW-1:0]          chan_t;
    typedef chan_t [NUM_CH-1:0]         fmap_t;
    typedef logic [COORD_BW-1:0]        coord_t;
    typedef logic signed [W_BW-1:0]     weight_t;
    typedef logic signed [ACC_BW-1:0]   acc_t;

    // =========================================================================
    // fixed kernel, indexed [channel][ky][kx], ky 0 is the oldest row
    // =========================================================================
    localparam weight_t CONV_WEIGHT [NUM_CH][KSIZE][KSIZE] = '{
        // horizontal edge: top minus bottom
        '{
            '{ 1,  1,  1},
            '{ 0,  0,  0},
            '{-1, -1, -1}
        },
        // box filter
        '{
            '{ 1,  1,  1},
            '{ 1,  1,  1},
            '{ 1,  1,  1}
        }
    };

    // added before the shift
    localparam acc_t CONV_BIAS [NUM_CH] = '{0, -8};

endpackage

//--- common/fmap_stream_if.sv
`timescale 1ns/100ps

// valid-only stream, one item per cycle with valid high
interface fmap_stream_if #(
    parameter type T = cnn_pkg::pixel_t
);
    logic            valid;
    T                data;
    // position of the item inside its own map
    cnn_pkg::coord_t col;
    cnn_pkg::coord_t row;

    modport source (
        output valid,
        output data,
        output col,
        output row
    );

    modport sink (
        input valid,
        input data,
        input col,
        input row
    );
endinterface

//--- design/line_buffer.sv
`timescale 1ns/100ps

module line_buffer #(
    parameter type T      = cnn_pkg::pixel_t,
    parameter int  LINE_W = cnn_pkg::IMG_W
) (
    input  logic clk,
    input  logic reset_n,
    input  logic i_shift,
    input  T     i_data,
    output T     o_row1,
    output T     o_row2
);
    // chain1 holds the previous row, chain2 the row before it
    T chain1 [LINE_W];
    T chain2 [LINE_W];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < LINE_W; i++) begin
                chain1[i] <= '0;
                chain2[i] <= '0;
            end
        end else if (i_shift) begin
            chain1[0] <= i_data;
            // row above spills into the second chain
            chain2[0] <= chain1[LINE_W-1];
            for (int i = 1; i < LINE_W; i++) begin
                chain1[i] <= chain1[i-1];
                chain2[i] <= chain2[i-1];
            end
        end
    end

    // tail of each chain is exactly one line behind its head
    assign o_row1 = chain1[LINE_W-1];
    assign o_row2 = chain2[LINE_W-1];

endmodule

//--- conv/conv3x3_stage.sv
`timescale 1ns/100ps

module conv3x3_stage (
    input  logic          clk,
    input  logic          reset_n,
    fmap_stream_if.sink   i_pix,
    fmap_stream_if.source o_conv
);
    cnn_pkg::pixel_t row1;
    cnn_pkg::pixel_t row2;
    cnn_pkg::pixel_t col_in [cnn_pkg::KSIZE];
    cnn_pkg::pixel_t win_q  [cnn_pkg::KSIZE][cnn_pkg::KSIZE-1];
    cnn_pkg::pixel_t win    [cnn_pkg::KSIZE][cnn_pkg::KSIZE];
    cnn_pkg::acc_t   acc    [cnn_pkg::NUM_CH];
    cnn_pkg::acc_t   scaled [cnn_pkg::NUM_CH];
    cnn_pkg::fmap_t  relu;
    logic            win_ready;

    // =========================================================================
    // row delay for the two rows above the current pixel
    // =========================================================================
    line_buffer #(
        .T      (cnn_pkg::pixel_t),
        .LINE_W (cnn_pkg::IMG_W)
    ) u_row_buf (
        .clk     (clk),
        .reset_n (reset_n),
        .i_shift (i_pix.valid),
        .i_data  (i_pix.data),
        .o_row1  (row1),
        .o_row2  (row2)
    );

    // newest window column, oldest row on top
    always_comb begin
        col_in[0] = row2;
        col_in[1] = row1;
        col_in[2] = i_pix.data;
    end

    // older columns shift left on every accepted pixel
    always_ff @(posedge clk) begin
        if (i_pix.valid) begin
            for (int ky = 0; ky < cnn_pkg::KSIZE; ky++) begin
                for (int kx = 0; kx < cnn_pkg::KSIZE - 2; kx++) begin
                    win_q[ky][kx] <= win_q[ky][kx+1];
                end
                win_q[ky][cnn_pkg::KSIZE-2] <= col_in[ky];
            end
        end
    end

    always_comb begin
        for (int ky = 0; ky < cnn_pkg::KSIZE; ky++) begin
            for (int kx = 0; kx < cnn_pkg::KSIZE - 1; kx++) begin
                win[ky][kx] = win_q[ky][kx];
            end
            win[ky][cnn_pkg::KSIZE-1] = col_in[ky];
        end
    end

    // =========================================================================
    // multiply-accumulate, shift, relu with saturation
    // =========================================================================
    always_comb begin
        for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
            acc[ch] = cnn_pkg::CONV_BIAS[ch];
            for (int ky = 0; ky < cnn_pkg::KSIZE; ky++) begin
                for (int kx = 0; kx < cnn_pkg::KSIZE; kx++) begin
                    acc[ch] = acc[ch]
                            + cnn_pkg::acc_t'(cnn_pkg::CONV_WEIGHT[ch][ky][kx])
                            * cnn_pkg::acc_t'($signed({1'b0, win[ky][kx]}));
                end
            end
            scaled[ch] = acc[ch] >>> cnn_pkg::SHIFT;
            if (scaled[ch] < 0) begin
                relu[ch] = '0;
            end else if (scaled[ch] > cnn_pkg::PIX_MAX) begin
                relu[ch] = cnn_pkg::chan_t'(cnn_pkg::PIX_MAX);
            end else begin
                relu[ch] = cnn_pkg::chan_t'(scaled[ch]);
            end
        end
    end

    // window is full once two columns and two rows have passed
    assign win_ready = i_pix.valid
                    && (i_pix.col >= cnn_pkg::KSIZE - 1)
                    && (i_pix.row >= cnn_pkg::KSIZE - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_conv.valid <= 1'b0;
        end else begin
            o_conv.valid <= win_ready;
        end
    end

    // output position is the top-left corner of the window
    always_ff @(posedge clk) begin
        if (win_ready) begin
            o_conv.data <= relu;
            o_conv.col  <= cnn_pkg::coord_t'(i_pix.col - (cnn_pkg::KSIZE - 1));
            o_conv.row  <= cnn_pkg::coord_t'(i_pix.row - (cnn_pkg::KSIZE - 1));
        end
    end

endmodule

//--- pool/maxpool_stage.sv
`timescale 1ns/100ps

module maxpool_stage (
    input  logic          clk,
    input  logic          reset_n,
    fmap_stream_if.sink   i_conv,
    fmap_stream_if.source o_pool
);
    cnn_pkg::fmap_t up;
    cnn_pkg::fmap_t left_q;
    cnn_pkg::fmap_t up_left_q;
    cnn_pkg::fmap_t pooled;
    logic           pool_hit;

    function automatic cnn_pkg::chan_t max2(
        input cnn_pkg::chan_t a,
        input cnn_pkg::chan_t b
    );
        return (a > b) ? a : b;
    endfunction

    // =========================================================================
    // one conv row of history, second row output left open
    // =========================================================================
    line_buffer #(
        .T      (cnn_pkg::fmap_t),
        .LINE_W (cnn_pkg::CONV_W)
    ) u_row_buf (
        .clk     (clk),
        .reset_n (reset_n),
        .i_shift (i_conv.valid),
        .i_data  (i_conv.data),
        .o_row1  (up),
        .o_row2  ()
    );

    // left neighbours of the current item and of the item above it
    always_ff @(posedge clk) begin
        if (i_conv.valid) begin
            left_q    <= i_conv.data;
            up_left_q <= up;
        end
    end

    always_comb begin
        for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
            pooled[ch] = max2(max2(left_q[ch], i_conv.data[ch]),
                              max2(up_left_q[ch], up[ch]));
        end
    end

    // bottom-right corner of each 2x2 block
    assign pool_hit = i_conv.valid && i_conv.col[0] && i_conv.row[0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_pool.valid <= 1'b0;
        end else begin
            o_pool.valid <= pool_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (pool_hit) begin
            o_pool.data <= pooled;
            o_pool.col  <= i_conv.col >> 1;
            o_pool.row  <= i_conv.row >> 1;
        end
    end

endmodule

//--- design/class_stage.sv
`timescale 1ns/100ps

module class_stage (
    input  logic                        clk,
    input  logic                        reset_n,
    fmap_stream_if.sink                 i_pool,
    output logic                        o_valid,
    output logic                        o_class,
    output logic [cnn_pkg::SUM_BW-1:0]  o_score
);
    logic [cnn_pkg::SUM_BW-1:0] sum_q    [cnn_pkg::NUM_CH];
    logic [cnn_pkg::SUM_BW-1:0] sum_next [cnn_pkg::NUM_CH];
    logic                       first_item;
    logic                       last_item;

    assign first_item = (i_pool.col == 0) && (i_pool.row == 0);
    assign last_item  = (i_pool.col == cnn_pkg::POOL_W - 1)
                     && (i_pool.row == cnn_pkg::POOL_H - 1);

    // running sum including the current item, restarted at (0,0)
    always_comb begin
        for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
            sum_next[ch] = (first_item ? '0 : sum_q[ch])
                         + cnn_pkg::SUM_BW'(i_pool.data[ch]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
                sum_q[ch] <= '0;
            end
        end else if (i_pool.valid) begin
            for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
                sum_q[ch] <= sum_next[ch];
            end
        end
    end

    // =========================================================================
    // decision, channel 0 wins a tie
    // =========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
            o_class <= 1'b0;
            o_score <= '0;
        end else begin
            o_valid <= i_pool.valid && last_item;
            if (i_pool.valid && last_item) begin
                if (sum_next[1] > sum_next[0]) begin
                    o_class <= 1'b1;
                    o_score <= sum_next[1];
                end else begin
                    o_class <= 1'b0;
                    o_score <= sum_next[0];
                end
            end
        end
    end

endmodule

//--- design/cnn_top.sv
`timescale 1ns/100ps

module cnn_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_valid,
    input  logic [cnn_pkg::PIX_BW-1:0]  i_pixel,
    output logic                        o_valid,
    output logic                        o_class,
    output logic [cnn_pkg::SUM_BW-1:0]  o_score
);
    cnn_pkg::coord_t col_cnt;
    cnn_pkg::coord_t row_cnt;

    fmap_stream_if #(.T(cnn_pkg::pixel_t)) pix_s  ();
    fmap_stream_if #(.T(cnn_pkg::fmap_t))  conv_s ();
    fmap_stream_if #(.T(cnn_pkg::fmap_t))  pool_s ();

    // =========================================================================
    // raster position of the incoming pixel
    // =========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_valid) begin
            if (col_cnt == cnn_pkg::IMG_W - 1) begin
                col_cnt <= '0;
                // wrap at frame end so the next frame starts at (0,0)
                if (row_cnt == cnn_pkg::IMG_H - 1) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // pixel stream, same cycle as the input
    assign pix_s.valid = i_valid;
    assign pix_s.data  = i_pixel;
    assign pix_s.col   = col_cnt;
    assign pix_s.row   = row_cnt;

    conv3x3_stage u_conv (
        .clk     (clk),
        .reset_n (reset_n),
        .i_pix   (pix_s),
        .o_conv  (conv_s)
    );

    maxpool_stage u_pool (
        .clk     (clk),
        .reset_n (reset_n),
        .i_conv  (conv_s),
        .o_pool  (pool_s)
    );

    class_stage u_class (
        .clk     (clk),
        .reset_n (reset_n),
        .i_pool  (pool_s),
        .o_valid (o_valid),
        .o_class (o_class),
        .o_score (o_score)
    );

endmodule

//--- testbench/cnn_assertions.sv
`timescale 1ns/100ps

module cnn_assertions (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       i_valid,
    input cnn_pkg::coord_t            col_cnt,
    input cnn_pkg::coord_t            row_cnt,
    input logic                       conv_valid,
    input cnn_pkg::fmap_t             conv_data,
    input logic                       pool_valid,
    input cnn_pkg::fmap_t             pool_data,
    input logic                       o_valid,
    input logic                       o_class,
    input logic [cnn_pkg::SUM_BW-1:0] o_score
);
    // one result per frame, never two in a row
    a_single_pulse : assert property (@(posedge clk) disable iff (!reset_n)
        o_valid |=> !o_valid)
        else $error("o_valid held high for two cycles");

    a_out_known : assert property (@(posedge clk) disable iff (!reset_n)
        o_valid |-> !$isunknown({o_class, o_score}))
        else $error("unknown value on class or score");

    a_conv_known : assert property (@(posedge clk) disable iff (!reset_n)
        conv_valid |-> !$isunknown(conv_data))
        else $error("unknown value on conv stream");

    a_pool_known : assert property (@(posedge clk) disable iff (!reset_n)
        pool_valid |-> !$isunknown(pool_data))
        else $error("unknown value on pool stream");

    // last pixel to result latency
    a_latency : assert property (@(posedge clk) disable iff (!reset_n)
        (i_valid && col_cnt == cnn_pkg::IMG_W - 1 && row_cnt == cnn_pkg::IMG_H - 1)
        |-> ##3 o_valid)
        else $error("result missing 3 cycles after the last pixel");

endmodule

bind cnn_top cnn_assertions u_assertions (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_valid    (i_valid),
    .col_cnt    (col_cnt),
    .row_cnt    (row_cnt),
    .conv_valid (conv_s.valid),
    .conv_data  (conv_s.data),
    .pool_valid (pool_s.valid),
    .pool_data  (pool_s.data),
    .o_valid    (o_valid),
    .o_class    (o_class),
    .o_score    (o_score)
);

//--- testbench/cnn_tb.sv
`timescale 1ns/100ps

module cnn_tb;

    localparam int PAT_ZERO   = 0;
    localparam int PAT_FULL   = 1;
    localparam int PAT_STRIPE = 2;
    localparam int PAT_GRAD   = 3;
    localparam int PAT_RAND   = 4;
    localparam int PAT_SPOT   = 5;
    localparam int NO_CHECK   = -1;

    localparam int NUM_FRAMES  = 14;
    localparam int MAX_IDLE    = 3;
    localparam int FRAME_PIX   = cnn_pkg::IMG_W * cnn_pkg::IMG_H;
    localparam int CYCLE_LIMIT = 2 * NUM_FRAMES * (FRAME_PIX + FRAME_PIX * MAX_IDLE) + 20;

    // pattern, idle gaps, new random fill, expected class, expected score
    typedef struct packed {
        int pattern;
        bit gaps;
        bit fresh;
        int exp_class;
        int exp_score;
    } stim_t;

    localparam stim_t STIM [NUM_FRAMES] = '{
        '{PAT_ZERO,   1'b0, 1'b0, 0,        0},
        '{PAT_FULL,   1'b0, 1'b0, 1,        2295},
        '{PAT_STRIPE, 1'b0, 1'b0, 0,        573},
        '{PAT_GRAD,   1'b0, 1'b0, 0,        573},
        '{PAT_RAND,   1'b0, 1'b1, NO_CHECK, NO_CHECK},
        '{PAT_RAND,   1'b1, 1'b0, NO_CHECK, NO_CHECK},
        '{PAT_SPOT,   1'b1, 1'b0, NO_CHECK, NO_CHECK},
        '{PAT_ZERO,   1'b0, 1'b0, 0,        0},
        '{PAT_FULL,   1'b1, 1'b0, 1,        2295},
        '{PAT_STRIPE, 1'b1, 1'b0, 0,        573},
        '{PAT_RAND,   1'b0, 1'b1, NO_CHECK, NO_CHECK},
        '{PAT_RAND,   1'b1, 1'b0, NO_CHECK, NO_CHECK},
        '{PAT_GRAD,   1'b1, 1'b0, 0,        573},
        '{PAT_ZERO,   1'b0, 1'b0, 0,        0}
    };

    logic        clk = 1'b0;
    logic        reset_n;
    logic        i_valid;
    logic [7:0]  i_pixel;
    logic        o_valid;
    logic        o_class;
    logic [11:0] o_score;

    int          frame_pix [cnn_pkg::IMG_H][cnn_pkg::IMG_W];
    int          rand_pix  [cnn_pkg::IMG_H][cnn_pkg::IMG_W];
    int          exp_class_q [$];
    int          exp_score_q [$];
    int          exp_class;
    int          exp_score;
    int          model_class;
    int          model_score;
    int          error_count = 0;
    int          cycle_cnt = 0;

    cnn_top u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (i_valid),
        .i_pixel (i_pixel),
        .o_valid (o_valid),
        .o_class (o_class),
        .o_score (o_score)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic int relu_sat(input int v);
        if (v < 0) begin
            return 0;
        end
        return (v > 255) ? 255 : v;
    endfunction

    function automatic void model_frame(
        input  int pix [cnn_pkg::IMG_H][cnn_pkg::IMG_W],
        output int cls,
        output int score
    );
        int fmap [2][cnn_pkg::CONV_H][cnn_pkg::CONV_W];
        int sum  [2];
        int top;
        int mid;
        int bot;
        int best;
        sum[0] = 0;
        sum[1] = 0;
        for (int r = 0; r < cnn_pkg::CONV_H; r++) begin
            for (int c = 0; c < cnn_pkg::CONV_W; c++) begin
                top = pix[r][c] + pix[r][c+1] + pix[r][c+2];
                mid = pix[r+1][c] + pix[r+1][c+1] + pix[r+1][c+2];
                bot = pix[r+2][c] + pix[r+2][c+1] + pix[r+2][c+2];
                // edge channel is top minus bottom with no bias
                // box channel sums all nine and subtracts 8
                fmap[0][r][c] = relu_sat((top - bot) >>> 2);
                fmap[1][r][c] = relu_sat((top + mid + bot - 8) >>> 2);
            end
        end
        for (int ch = 0; ch < 2; ch++) begin
            for (int pr = 0; pr < cnn_pkg::POOL_H; pr++) begin
                for (int pc = 0; pc < cnn_pkg::POOL_W; pc++) begin
                    best = 0;
                    for (int dy = 0; dy < 2; dy++) begin
                        for (int dx = 0; dx < 2; dx++) begin
                            if (fmap[ch][2*pr+dy][2*pc+dx] > best) begin
                                best = fmap[ch][2*pr+dy][2*pc+dx];
                            end
                        end
                    end
                    sum[ch] += best;
                end
            end
        end
        // tie goes to channel 0
        cls   = (sum[1] > sum[0]) ? 1 : 0;
        score = sum[cls];
    endfunction

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic build_frame(input int pattern, input bit fresh);
        for (int r = 0; r < cnn_pkg::IMG_H; r++) begin
            for (int c = 0; c < cnn_pkg::IMG_W; c++) begin
                if (fresh) begin
                    rand_pix[r][c] = $urandom_range(255, 0);
                end
                case (pattern)
                    PAT_FULL:   frame_pix[r][c] = 255;
                    PAT_STRIPE: frame_pix[r][c] = (r == 0) ? 255 : 0;
                    // steep falloff 255, 1, 0 down the frame
                    PAT_GRAD:   frame_pix[r][c] = (r < 2) ? (255 >> (7 * r)) : 0;
                    PAT_RAND:   frame_pix[r][c] = rand_pix[r][c];
                    PAT_SPOT:   frame_pix[r][c] = (r == 3 && c == 4) ? 255 : 0;
                    default:    frame_pix[r][c] = 0;
                endcase
            end
        end
    endtask

    task automatic send_frame(input bit gaps);
        int idle;
        for (int r = 0; r < cnn_pkg::IMG_H; r++) begin
            for (int c = 0; c < cnn_pkg::IMG_W; c++) begin
                idle = gaps ? $urandom_range(MAX_IDLE, 0) : 0;
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                    i_valid = 1'b0;
                end
                @(posedge clk);
                #1;
                i_valid = 1'b1;
                i_pixel = frame_pix[r][c][7:0];
            end
        end
    endtask

    initial begin
        void'($urandom(32'h986d2de5));
        reset_n  = 1'b0;
        i_valid  = 1'b0;
        i_pixel  = '0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_frame(STIM[f].pattern, STIM[f].fresh);
            model_frame(frame_pix, model_class, model_score);
            if (STIM[f].exp_class != NO_CHECK) begin
                check_value("model class vs table", model_class, STIM[f].exp_class);
                check_value("model score vs table", model_score, STIM[f].exp_score);
            end
            exp_class_q.push_back(model_class);
            exp_score_q.push_back(model_score);
            send_frame(STIM[f].gaps);
        end
        @(posedge clk);
        #1;
        i_valid = 1'b0;

        while (exp_class_q.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray extra result
        repeat (5) @(posedge clk);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // results are sampled mid-cycle
    always @(negedge clk) begin
        if (reset_n && o_valid) begin
            if (exp_class_q.size() == 0) begin
                $display("A result came out at %0t ns with no frame pending.", $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "unexpected result");
            end else begin
                exp_class = exp_class_q.pop_front();
                exp_score = exp_score_q.pop_front();
                check_value("o_class", int'(o_class), exp_class);
                check_value("o_score", int'(o_score), exp_score);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("The run did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- sources.f
common/cnn_pkg.sv
common/fmap_stream_if.sv
design/line_buffer.sv
conv/conv3x3_stage.sv
pool/maxpool_stage.sv
design/class_stage.sv
design/cnn_top.sv
testbench/cnn_assertions.sv
testbench/cnn_tb.sv
